/* design/mul_pkg.sv */
/*
 * Shared constants and types for the packed-SIMD multiply unit.
 * Referenced by scoped name from the RTL and the testbench model.
 */
package mul_pkg;

    // element width select
    localparam int unsigned SEW_W = 2;

    localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
    localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
    localparam logic [SEW_W-1:0] SEW_32 = 2'd2;

    // one lane group feeds four 17x17 blocks
    localparam int unsigned LANE_GROUP_W = 32;

    // top-level defaults
    localparam int unsigned DEFAULT_OP_W        = 64;
    localparam int unsigned DEFAULT_QUEUE_DEPTH = 4;

    // one lane group seen as bytes, halfwords or a single word
    typedef union packed {
        logic [3:0][7:0]          b;
        logic [1:0][15:0]         h;
        logic [LANE_GROUP_W-1:0]  w;
    } lane_group_u;

endpackage

/* design/mul_issue_if.sv */
/*
 * Carries one accepted multiply operation from the request receiver
 * into the lane array. No back-pressure, valid is a one-cycle pulse.
 */
`timescale 1ns/1ps

interface mul_issue_if #(
    parameter int unsigned OP_W = 64
);

    logic                        valid;
    logic [mul_pkg::SEW_W-1:0]   sew;
    logic                        high;
    logic                        a_signed;
    logic                        b_signed;
    logic [OP_W-1:0]             op_a;
    logic [OP_W-1:0]             op_b;

    modport rx    (output valid, sew, high, a_signed, b_signed, op_a, op_b);
    modport lanes (input  valid, sew, high, a_signed, b_signed, op_a, op_b);

endinterface

/* design/mul_block17.sv */
/*
 * Registered signed 17x17 multiplier, the arithmetic cell of the lane array.
 */
`timescale 1ns/1ps

module mul_block17 (
    input  logic               clk_i,
    input  logic signed [16:0] op_a_i,
    input  logic signed [16:0] op_b_i,
    output logic signed [33:0] prod_o
);

    // 17 bits cover a sign- or zero-extended 16-bit operand,
    // so the 34-bit product never overflows
    logic signed [33:0] prod;

    assign prod = op_a_i * op_b_i;

    // output is qualified by the valid pipeline in the lane array
    always_ff @(posedge clk_i) begin
        prod_o <= prod;
    end

endmodule

/* design/mul_req_rx.sv */
/*
 * Input side of the multiply unit. Runs the four-phase receive handshake
 * and issues each accepted operation into the lane array.
 */
`timescale 1ns/1ps

module mul_req_rx #(
    parameter int unsigned OP_W = 64
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       in_req_i,
    output logic                       in_ack_o,
    input  logic [mul_pkg::SEW_W-1:0]  in_sew_i,
    input  logic                       in_high_i,
    input  logic                       in_a_signed_i,
    input  logic                       in_b_signed_i,
    input  logic [OP_W-1:0]            in_a_i,
    input  logic [OP_W-1:0]            in_b_i,
    input  logic                       slot_free_i,
    output logic                       issue_o,
    mul_issue_if.rx                    issue
);

    logic ack_q;
    logic valid_q;
    logic accept;

    // new request, previous cycle finished and room in the result queue
    assign accept = in_req_i & ~ack_q & slot_free_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                ack_q <= 1'b1;
            end else if (ack_q && !in_req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    // operation fields held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            issue.sew      <= in_sew_i;
            issue.high     <= in_high_i;
            issue.a_signed <= in_a_signed_i;
            issue.b_signed <= in_b_signed_i;
            issue.op_a     <= in_a_i;
            issue.op_b     <= in_b_i;
        end
    end

    assign in_ack_o    = ack_q;
    assign issue.valid = valid_q;
    assign issue_o     = valid_q;

endmodule

/* design/mul_lane_array.sv */
/*
 * Arithmetic core. Arranges operands for 8/16/32-bit elements, runs one
 * 17x17 block per byte and composes the low or high product halves.
 */
`timescale 1ns/1ps

module mul_lane_array #(
    parameter int unsigned OP_W = 64
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    mul_issue_if.lanes      issue,
    output logic            res_valid_o,
    output logic [OP_W-1:0] res_data_o
);

    localparam int unsigned LG     = mul_pkg::LANE_GROUP_W;
    localparam int unsigned GROUPS = OP_W / LG;

    if (OP_W % LG != 0 || GROUPS == 0) begin : g_bad_width
        $fatal(1, "OP_W must be a nonzero multiple of %0d", LG);
    end

    // stage 1 control, runs alongside the block registers
    logic                       valid_q;
    logic [mul_pkg::SEW_W-1:0]  sew_q;
    logic                       high_q;
    logic [OP_W-1:0]            res_d;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            valid_q     <= issue.valid;
            res_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        sew_q      <= issue.sew;
        high_q     <= issue.high;
        res_data_o <= res_d;
    end

    for (genvar g = 0; g < GROUPS; g++) begin : g_group
        mul_pkg::lane_group_u a_grp;
        mul_pkg::lane_group_u b_grp;
        logic signed [16:0]   opa  [4];
        logic signed [16:0]   opb  [4];
        logic signed [33:0]   prod [4];
        logic [63:0]          p32;
        logic [LG-1:0]        grp_res;

        assign a_grp.w = issue.op_a[LG*g +: LG];
        assign b_grp.w = issue.op_b[LG*g +: LG];

        //////////////////////////////////////////////////////////
        // operand arrangement
        always_comb begin
            case (issue.sew)
                mul_pkg::SEW_16: begin
                    // halfwords on blocks 0 and 2, blocks 1 and 3 idle
                    for (int h = 0; h < 2; h++) begin
                        opa[2*h]   = {issue.a_signed & a_grp.h[h][15], a_grp.h[h]};
                        opb[2*h]   = {issue.b_signed & b_grp.h[h][15], b_grp.h[h]};
                        opa[2*h+1] = '0;
                        opb[2*h+1] = '0;
                    end
                end
                mul_pkg::SEW_32: begin
                    // cross products, only the upper halves carry a sign
                    opa[0] = {1'b0, a_grp.h[0]};
                    opb[0] = {1'b0, b_grp.h[0]};
                    opa[1] = {1'b0, a_grp.h[0]};
                    opb[1] = {issue.b_signed & b_grp.h[1][15], b_grp.h[1]};
                    opa[2] = {issue.a_signed & a_grp.h[1][15], a_grp.h[1]};
                    opb[2] = {issue.b_signed & b_grp.h[1][15], b_grp.h[1]};
                    opa[3] = {issue.a_signed & a_grp.h[1][15], a_grp.h[1]};
                    opb[3] = {1'b0, b_grp.h[0]};
                end
                default: begin
                    for (int k = 0; k < 4; k++) begin
                        opa[k] = {{9{issue.a_signed & a_grp.b[k][7]}}, a_grp.b[k]};
                        opb[k] = {{9{issue.b_signed & b_grp.b[k][7]}}, b_grp.b[k]};
                    end
                end
            endcase
        end

        for (genvar k = 0; k < 4; k++) begin : g_block
            mul_block17 u_block (
                .clk_i  (clk_i),
                .op_a_i (opa[k]),
                .op_b_i (opb[k]),
                .prod_o (prod[k])
            );
        end

        //////////////////////////////////////////////////////////
        // result composition
        // lo*lo + (lo*hi + hi*lo) << 16 + hi*hi << 32
        assign p32 = 64'(prod[0]) + (64'(prod[1]) << 16) + (64'(prod[3]) << 16)
                   + (64'(prod[2]) << 32);

        always_comb begin
            grp_res = '0;
            case (sew_q)
                mul_pkg::SEW_8: begin
                    for (int k = 0; k < 4; k++) begin
                        grp_res[8*k +: 8] = high_q ? prod[k][15:8] : prod[k][7:0];
                    end
                end
                mul_pkg::SEW_16: begin
                    for (int h = 0; h < 2; h++) begin
                        grp_res[16*h +: 16] = high_q ? prod[2*h][31:16] : prod[2*h][15:0];
                    end
                end
                mul_pkg::SEW_32: grp_res = high_q ? p32[63:32] : p32[31:0];
                default: grp_res = '0;
            endcase
        end

        assign res_d[LG*g +: LG] = grp_res;
    end

endmodule

/* design/mul_result_tx.sv */
/*
 * Output side. Queues results in issue order, reserves a slot per issued
 * operation and runs the four-phase send handshake from the queue head.
 */
`timescale 1ns/1ps

module mul_result_tx #(
    parameter int unsigned OP_W        = 64,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            issue_i,
    output logic            slot_free_o,
    input  logic            res_valid_i,
    input  logic [OP_W-1:0] res_data_i,
    output logic            out_req_o,
    input  logic            out_ack_i,
    output logic [OP_W-1:0] out_data_o
);

    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    if (QUEUE_DEPTH < 2) begin : g_bad_depth
        $fatal(1, "QUEUE_DEPTH must be at least 2");
    end

    logic [OP_W-1:0]  mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] used_q;
    logic [CNT_W-1:0] resv_q;
    logic             req_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // phase 3, ack seen while requesting
    assign pop = req_q & out_ack_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            used_q   <= '0;
            resv_q   <= '0;
            req_q    <= 1'b0;
        end else begin
            if (res_valid_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            used_q <= used_q + CNT_W'(res_valid_i) - CNT_W'(pop);
            resv_q <= resv_q + CNT_W'(issue_i) - CNT_W'(pop);
            // a new request waits for the sink to drop ack
            if (pop) begin
                req_q <= 1'b0;
            end else if (!req_q && !out_ack_i && used_q != '0) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            mem[wr_ptr_q] <= res_data_i;
        end
    end

    // reservations include results already queued
    assign slot_free_o = resv_q < CNT_W'(QUEUE_DEPTH);
    assign out_req_o   = req_q;
    assign out_data_o  = mem[rd_ptr_q];

endmodule

/* design/mul_unit.sv */
/*
 * Top level of the packed-SIMD multiply unit, four-phase req/ack on both
 * sides. Set OP_W and QUEUE_DEPTH here, they pass down to all blocks.
 */
`timescale 1ns/1ps

module mul_unit #(
    parameter int unsigned OP_W        = mul_pkg::DEFAULT_OP_W,
    parameter int unsigned QUEUE_DEPTH = mul_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       in_req_i,
    output logic                       in_ack_o,
    input  logic [mul_pkg::SEW_W-1:0]  in_sew_i,
    input  logic                       in_high_i,
    input  logic                       in_a_signed_i,
    input  logic                       in_b_signed_i,
    input  logic [OP_W-1:0]            in_a_i,
    input  logic [OP_W-1:0]            in_b_i,
    output logic                       out_req_o,
    input  logic                       out_ack_i,
    output logic [OP_W-1:0]            out_data_o
);

    logic            issue_pulse;
    logic            slot_free;
    logic            res_valid;
    logic [OP_W-1:0] res_data;

    mul_issue_if #(.OP_W(OP_W)) issue_bus ();

    mul_req_rx #(.OP_W(OP_W)) u_req_rx (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .in_req_i      (in_req_i),
        .in_ack_o      (in_ack_o),
        .in_sew_i      (in_sew_i),
        .in_high_i     (in_high_i),
        .in_a_signed_i (in_a_signed_i),
        .in_b_signed_i (in_b_signed_i),
        .in_a_i        (in_a_i),
        .in_b_i        (in_b_i),
        .slot_free_i   (slot_free),
        .issue_o       (issue_pulse),
        .issue         (issue_bus.rx)
    );

    // two-cycle arithmetic pipeline
    mul_lane_array #(.OP_W(OP_W)) u_lanes (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .issue       (issue_bus.lanes),
        .res_valid_o (res_valid),
        .res_data_o  (res_data)
    );

    mul_result_tx #(
        .OP_W        (OP_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_result_tx (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .issue_i     (issue_pulse),
        .slot_free_o (slot_free),
        .res_valid_i (res_valid),
        .res_data_i  (res_data),
        .out_req_o   (out_req_o),
        .out_ack_i   (out_ack_i),
        .out_data_o  (out_data_o)
    );

endmodule

/* dv/mul_unit_assert.sv */
/*
 * Four-phase protocol checks on the multiply unit ports, bound to mul_unit.
 */
`timescale 1ns/1ps

module mul_unit_assert #(
    parameter int unsigned OP_W = 64
) (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            in_req_i,
    input logic            in_ack_i,
    input logic            out_req_i,
    input logic            out_ack_i,
    input logic [OP_W-1:0] out_data_i
);

    // ack only answers a pending request
    ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(in_ack_i) |-> $past(in_req_i))
        else $error("in_ack_o rose without in_req_i");

    // request held until the sink acknowledges
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_req_i && !out_ack_i |=> out_req_i)
        else $error("out_req_o dropped before out_ack_i");

    data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_req_i && !out_ack_i |=> $stable(out_data_i))
        else $error("out_data_o changed during a request");

endmodule

bind mul_unit mul_unit_assert #(.OP_W(OP_W)) u_assert (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_req_i   (in_req_i),
    .in_ack_i   (in_ack_o),
    .out_req_i  (out_req_o),
    .out_ack_i  (out_ack_i),
    .out_data_i (out_data_o)
);

/* dv/tb_mul_unit.sv */
/*
 * Testbench for the packed-SIMD multiply unit. Runs directed and LFSR random
 * operations through both four-phase ports and checks against a model.
 */
`timescale 1ns/1ps

module tb_mul_unit;

    localparam int unsigned OP_W    = mul_pkg::DEFAULT_OP_W;
    localparam int unsigned LG      = mul_pkg::LANE_GROUP_W;
    localparam int          TIMEOUT = 200;
    localparam int          N_RAND  = 48;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      in_req;
    logic                      in_ack;
    logic [mul_pkg::SEW_W-1:0] in_sew;
    logic                      in_high;
    logic                      in_a_signed;
    logic                      in_b_signed;
    logic [OP_W-1:0]           in_a;
    logic [OP_W-1:0]           in_b;
    logic                      out_req;
    logic                      out_ack;
    logic [OP_W-1:0]           out_data;

    // one entry per operation in issue order
    string                     name_q [$];
    logic [mul_pkg::SEW_W-1:0] sew_q  [$];
    logic                      high_q [$];
    logic                      as_q   [$];
    logic                      bs_q   [$];
    logic [OP_W-1:0]           a_q    [$];
    logic [OP_W-1:0]           b_q    [$];
    logic [OP_W-1:0]           exp_q  [$];
    int                        extra_reqs;
    logic [31:0]               lfsr = 32'd87;

    mul_unit #(
        .OP_W (OP_W)
    ) dut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .in_req_i      (in_req),
        .in_ack_o      (in_ack),
        .in_sew_i      (in_sew),
        .in_high_i     (in_high),
        .in_a_signed_i (in_a_signed),
        .in_b_signed_i (in_b_signed),
        .in_a_i        (in_a),
        .in_b_i        (in_b),
        .out_req_o     (out_req),
        .out_ack_i     (out_ack),
        .out_data_o    (out_data)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // galois lfsr on x^32+x^22+x^2+x+1
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [OP_W-1:0] rand_word();
        logic [OP_W-1:0] v;
        for (int g = 0; g < OP_W / LG; g++) begin
            v[LG*g +: LG] = rand_bits(32);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    function automatic logic [63:0] extend(input logic [31:0] v, input int w,
                                           input logic sgn);
        logic [63:0] r;
        r = {32'd0, v};
        for (int i = w; i < 64; i++) begin
            r[i] = sgn & v[w-1];
        end
        return r;
    endfunction

    // full product then the low or high element-width half
    function automatic logic [31:0] elem_mul(input logic [31:0] a, input logic [31:0] b,
                                             input int w, input logic a_sgn,
                                             input logic b_sgn, input logic high);
        logic [63:0] p;
        p = extend(a, w, a_sgn) * extend(b, w, b_sgn);
        return high ? 32'(p >> w) : p[31:0];
    endfunction

    function automatic logic [OP_W-1:0] model_word(input logic [mul_pkg::SEW_W-1:0] sew,
                                                   input logic high, input logic a_sgn,
                                                   input logic b_sgn,
                                                   input logic [OP_W-1:0] a,
                                                   input logic [OP_W-1:0] b);
        mul_pkg::lane_group_u ga;
        mul_pkg::lane_group_u gb;
        mul_pkg::lane_group_u gr;
        logic [31:0]          t;
        logic [OP_W-1:0]      r;
        for (int g = 0; g < OP_W / LG; g++) begin
            ga.w = a[LG*g +: LG];
            gb.w = b[LG*g +: LG];
            case (sew)
                mul_pkg::SEW_8: begin
                    for (int k = 0; k < 4; k++) begin
                        t = elem_mul({24'd0, ga.b[k]}, {24'd0, gb.b[k]}, 8, a_sgn, b_sgn, high);
                        gr.b[k] = t[7:0];
                    end
                end
                mul_pkg::SEW_16: begin
                    for (int h = 0; h < 2; h++) begin
                        t = elem_mul({16'd0, ga.h[h]}, {16'd0, gb.h[h]}, 16, a_sgn, b_sgn,
                                     high);
                        gr.h[h] = t[15:0];
                    end
                end
                default: begin
                    gr.w = elem_mul(ga.w, gb.w, 32, a_sgn, b_sgn, high);
                end
            endcase
            r[LG*g +: LG] = gr.w;
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [OP_W-1:0] exp,
                              input logic [OP_W-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("error %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("error %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic add_op(input string name, input logic [mul_pkg::SEW_W-1:0] sew,
                          input logic high, input logic a_sgn, input logic b_sgn,
                          input logic [OP_W-1:0] a, input logic [OP_W-1:0] b);
        name_q.push_back(name);
        sew_q.push_back(sew);
        high_q.push_back(high);
        as_q.push_back(a_sgn);
        bs_q.push_back(b_sgn);
        a_q.push_back(a);
        b_q.push_back(b);
        exp_q.push_back(model_word(sew, high, a_sgn, b_sgn, a, b));
    endtask

    task automatic build_ops();
        logic [31:0]               r;
        logic [mul_pkg::SEW_W-1:0] sew;
        logic [OP_W-1:0]           a;
        logic [OP_W-1:0]           b;
        for (int i = 0; i < 4; i++) begin
            a = rand_word();
            b = rand_word();
            add_op("low_sew8", mul_pkg::SEW_8, 1'b0, i[1], i[0], a, b);
            add_op("low_sew8_edge", mul_pkg::SEW_8, 1'b0, i[1], i[0],
                   {(OP_W/32){32'h80FF_7F01}}, {(OP_W/32){32'h7F80_FF80}});
            a = rand_word();
            b = rand_word();
            add_op("high_sew16", mul_pkg::SEW_16, 1'b1, i[1], i[0], a, b);
            a = rand_word();
            b = rand_word();
            add_op("high_sew32", mul_pkg::SEW_32, 1'b1, i[1], i[0], a, b);
        end
        // most negative squared
        add_op("min_sq_sew16", mul_pkg::SEW_16, 1'b1, 1'b1, 1'b1,
               {(OP_W/16){16'h8000}}, {(OP_W/16){16'h8000}});
        add_op("min_sq_sew32", mul_pkg::SEW_32, 1'b1, 1'b1, 1'b1,
               {(OP_W/32){32'h8000_0000}}, {(OP_W/32){32'h8000_0000}});
        // unsigned by signed exercises the cross partials
        for (int i = 0; i < 8; i++) begin
            a = rand_word();
            b = rand_word();
            add_op("mixed_sew32", mul_pkg::SEW_32, i[0], i[1], ~i[1], a, b);
        end
        add_op("mixed_sew32_edge", mul_pkg::SEW_32, 1'b1, 1'b0, 1'b1,
               {(OP_W/32){32'hFFFF_FFFF}}, {(OP_W/32){32'h8000_0000}});
        for (int i = 0; i < N_RAND; i++) begin
            r   = rand_bits(2);
            sew = (r[1:0] == 2'd3) ? mul_pkg::SEW_32 : r[1:0];
            r   = rand_bits(3);
            a   = rand_word();
            b   = rand_word();
            add_op("random_backpressure", sew, r[2], r[1], r[0], a, b);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // handshake processes
    task automatic send_all();
        int t;
        for (int i = 0; i < exp_q.size(); i++) begin
            @(negedge clk);
            in_sew      = sew_q[i];
            in_high     = high_q[i];
            in_a_signed = as_q[i];
            in_b_signed = bs_q[i];
            in_a        = a_q[i];
            in_b        = b_q[i];
            in_req      = 1'b1;
            t = 0;
            while (in_ack !== 1'b1) begin
                @(negedge clk);
                t++;
                if (t > TIMEOUT) fail_now($sformatf("in_ack_o never rose in %s", name_q[i]));
            end
            in_req = 1'b0;
            t = 0;
            while (in_ack !== 1'b0) begin
                @(negedge clk);
                t++;
                if (t > TIMEOUT) fail_now($sformatf("in_ack_o never fell in %s", name_q[i]));
            end
        end
    endtask

    task automatic receive_all();
        int t;
        int delay;
        for (int i = 0; i < exp_q.size(); i++) begin
            t = 0;
            while (out_req !== 1'b1) begin
                @(negedge clk);
                t++;
                if (t > TIMEOUT) fail_now($sformatf("no result arrived for %s", name_q[i]));
            end
            check_word(name_q[i], exp_q[i], out_data);
            // sink stalls to fill the result queue
            delay = int'(rand_bits(3));
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            t = 0;
            while (out_req !== 1'b0) begin
                @(negedge clk);
                t++;
                if (t > TIMEOUT) fail_now($sformatf("out_req_o stuck high in %s", name_q[i]));
            end
            out_ack = 1'b0;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        in_req      = 1'b0;
        in_sew      = mul_pkg::SEW_8;
        in_high     = 1'b0;
        in_a_signed = 1'b0;
        in_b_signed = 1'b0;
        in_a        = '0;
        in_b        = '0;
        out_ack     = 1'b0;
        extra_reqs  = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet ports while idle
        repeat (4) begin
            @(negedge clk);
            check_flag("reset_idle_ack", 1'b0, in_ack);
            check_flag("reset_idle_req", 1'b0, out_req);
        end

        build_ops();
        fork
            send_all();
            receive_all();
        join

        // every result is back so nothing more may be offered
        repeat (8) begin
            @(negedge clk);
            if (out_req !== 1'b0) begin
                extra_reqs++;
            end
        end

        if (extra_reqs == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_now("out_req_o rose again after every operation had returned");
        end
    end

endmodule

/* verilog.f */
design/mul_pkg.sv
design/mul_issue_if.sv
design/mul_block17.sv
design/mul_req_rx.sv
design/mul_lane_array.sv
design/mul_result_tx.sv
design/mul_unit.sv
dv/mul_unit_assert.sv
dv/tb_mul_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mul_unit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
